/* vlog.f */
rtl/drp_map_pkg.sv
rtl/reconfig_ctrl_pkg.sv
rtl/divider_word_builder.sv
rtl/rmw_sequencer.sv
rtl/drp_access_port.sv
rtl/mmcm_reconfig_top.sv
bench/reconfig_properties.sv
bench/drp_clock_model.sv
bench/reconfig_checker.sv
bench/tb_mmcm_reconfig.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mmcm_reconfig -f vlog.f

status=0
./obj_dir/Vtb_mmcm_reconfig > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "No result line found in sim.log"
   exit 1
fi
exit 0

/* bench/tb_mmcm_reconfig.sv */
`timescale 1ns/1ns

module tb_mmcm_reconfig;

   localparam int ROWS    = 4;
   localparam int TIMEOUT = 1000;

   // Settings rows plus a flag for a stray start during the sequence
   localparam logic [27:0] CO0_TAB [ROWS] = '{28'h1234567, 28'hFEDCBA9,
                                              28'hA5A5A5A, 28'h3C0F0C3};
   localparam logic [27:0] CFB_TAB [ROWS] = '{28'h7654321, 28'h0123456,
                                              28'hFFFFFFF, 28'h5A5A5A5};
   localparam logic [13:0] DIV_TAB [ROWS] = '{14'h1041, 14'h3FFF, 14'h0000, 14'h2AAA};
   localparam bit          EXTRA_TAB [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};

   logic                           dclk;
   logic                           rst;
   logic                           start_reconfig;
   logic                           locked;
   logic                           ready;
   logic                           reconfig_done;
   logic                           mmcm_rst;
   logic [drp_map_pkg::ADDR_W-1:0] daddr;
   logic [drp_map_pkg::DATA_W-1:0] di;
   logic [drp_map_pkg::DATA_W-1:0] dout;
   logic                           den;
   logic                           dwe;
   logic                           drdy;
   logic [27:0]                    co0_set;
   logic [27:0]                    cfb_set;
   logic [13:0]                    div_set;
   int                             errors;
   int                             rows_done;
   integer                         seed;

   logic [5:0] clkout0_high_time, clkout0_low_time, clkout0_delay_time;
   logic [2:0] clkout0_phase_mux, clkout0_frac;
   logic       clkout0_frac_en, clkout0_wf_r, clkout0_edge, clkout0_no_count;
   logic [5:0] clkfbout_high_time, clkfbout_low_time, clkfbout_delay_time;
   logic [2:0] clkfbout_phase_mux, clkfbout_frac;
   logic       clkfbout_frac_en, clkfbout_wf_r, clkfbout_edge, clkfbout_no_count;
   logic [5:0] divclk_high_time, divclk_low_time;
   logic       divclk_edge, divclk_no_count;

   assign {clkout0_high_time, clkout0_low_time, clkout0_phase_mux, clkout0_frac,
           clkout0_frac_en, clkout0_wf_r, clkout0_edge, clkout0_no_count,
           clkout0_delay_time} = co0_set;
   assign {clkfbout_high_time, clkfbout_low_time, clkfbout_phase_mux, clkfbout_frac,
           clkfbout_frac_en, clkfbout_wf_r, clkfbout_edge, clkfbout_no_count,
           clkfbout_delay_time} = cfb_set;
   assign {divclk_high_time, divclk_low_time, divclk_edge, divclk_no_count} = div_set;

   mmcm_reconfig_top i_dut (.*);

   drp_clock_model i_model (.*);

   reconfig_checker i_check (.*);

   initial begin
      dclk = 1'b0;
      forever #4 dclk = ~dclk;
   end

   // Sampled on the falling edge away from the driving edge
   task automatic wait_for(input bit for_done, output bit ok);
      ok = 1'b0;
      for (int n = 0; n < TIMEOUT && !ok; n++) begin
         @(negedge dclk);
         ok = for_done ? reconfig_done : ready;
      end
      if (!ok) begin
         $display("Timeout at %0t: %s did not arrive within %0d cycles", $time,
                  for_done ? "reconfig_done" : "ready", TIMEOUT);
      end
   endtask

   task automatic run_row(input int r, output bit ok);
      wait_for(1'b0, ok);
      if (ok) begin
         @(posedge dclk);
         co0_set <= CO0_TAB[r];
         cfb_set <= CFB_TAB[r];
         div_set <= DIV_TAB[r];
         start_reconfig <= 1'b1;
         @(posedge dclk);
         start_reconfig <= 1'b0;
         // New inputs after the start must not reach the written words
         co0_set <= 28'($random(seed));
         cfb_set <= 28'($random(seed));
         div_set <= 14'($random(seed));
         if (EXTRA_TAB[r]) begin
            repeat (3) @(posedge dclk);
            start_reconfig <= 1'b1;
            @(posedge dclk);
            start_reconfig <= 1'b0;
         end
         wait_for(1'b1, ok);
      end
   endtask

   task automatic finish_run(input bit timed_out);
      $display("%0d of %0d rows done, %0d errors", rows_done, ROWS, errors);
      if (timed_out || errors != 0 || rows_done != ROWS) begin
         $display("SIMULATION FAILED");
      end else begin
         $display("SIMULATION PASSED");
      end
      $finish;
   endtask

   initial begin
      bit ok;
      seed = 68;
      rst = 1'b1;
      start_reconfig = 1'b0;
      co0_set = '0;
      cfb_set = '0;
      div_set = '0;
      repeat (3) @(posedge dclk);
      rst <= 1'b0;
      ok = 1'b1;
      for (int r = 0; r < ROWS && ok; r++) begin
         run_row(r, ok);
      end
      // Relock after the last row
      if (ok) begin
         wait_for(1'b0, ok);
      end
      finish_run(!ok);
   end

endmodule

/* bench/reconfig_checker.sv */
`timescale 1ns/1ns

module reconfig_checker (
   input  logic                           dclk,
   input  logic                           rst,
   input  logic                           ready,
   input  logic                           start_reconfig,
   input  logic                           reconfig_done,
   input  logic                           mmcm_rst,
   input  logic                           locked,
   input  logic [drp_map_pkg::ADDR_W-1:0] daddr,
   input  logic [drp_map_pkg::DATA_W-1:0] di,
   input  logic                           den,
   input  logic                           dwe,
   input  logic [drp_map_pkg::DATA_W-1:0] dout,
   input  logic                           drdy,
   input  logic [27:0]                    co0_set,
   input  logic [27:0]                    cfb_set,
   input  logic [13:0]                    div_set,
   output int                             errors,
   output int                             rows_done
);

   // Expected address and keep-mask of each step, in port order
   localparam logic [6:0]  ADDRS [6] = '{7'h28, 7'h08, 7'h09, 7'h16, 7'h14, 7'h15};
   localparam logic [15:0] MASKS [6] = '{16'h0000, 16'h1000, 16'h8000,
                                          16'hC000, 16'h1000, 16'h8000};

   logic [15:0] exp_data [6];
   logic [15:0] old_word;
   logic [15:0] exp_word;
   logic [6:0]  rd_addr;
   logic        in_seq;
   logic        rd_wait;
   logic        ready_q;
   logic        locked_q;
   int          n_rd;
   int          n_wr;
   int          row_err;

   // s holds high, low, phase_mux, frac, frac_en, wf_r, edge, no_count, delay
   function automatic logic [15:0] word1(input logic [27:0] s);
      return {s[15:13], 1'b0, s[27:22], s[21:16]};
   endfunction

   function automatic logic [15:0] word2(input logic [27:0] s);
      return {1'b0, s[12:10], s[9], s[8], 2'b00, s[7], s[6], s[5:0]};
   endfunction

   // s holds high, low, edge, no_count
   function automatic logic [15:0] div_word(input logic [13:0] s);
      return {2'b00, s[1], s[0], s[13:8], s[7:2]};
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
   endtask

   always @(posedge dclk) begin
      if (rst) begin
         errors = 0;
         rows_done = 0;
         in_seq = 1'b0;
         rd_wait = 1'b0;
         ready_q = 1'b0;
         locked_q = 1'b0;
         n_rd = 0;
         n_wr = 0;
         row_err = 0;
      end else begin
         if (ready && !ready_q && !locked_q) begin
            report_error("ready rose before locked was high");
         end
         if (ready && (in_seq || mmcm_rst)) begin
            report_error("ready high while the clock manager is being reprogrammed");
         end
         if (ready && start_reconfig) begin
            exp_data[0] = 16'hFFFF;
            exp_data[1] = word1(co0_set);
            exp_data[2] = word2(co0_set);
            exp_data[3] = div_word(div_set);
            exp_data[4] = word1(cfb_set);
            exp_data[5] = word2(cfb_set);
            in_seq = 1'b1;
            n_rd = 0;
            n_wr = 0;
            row_err = errors;
         end else if (in_seq && !mmcm_rst) begin
            report_error("mmcm_rst low during a reconfiguration");
         end
         if (drdy && rd_wait) begin
            old_word = dout;
            rd_wait = 1'b0;
         end
         if (den && !in_seq) begin
            report_error("port access with no reconfiguration running");
         end else if (den && !dwe) begin
            if (n_rd >= 6 || rd_wait) begin
               report_error("read issued out of turn");
            end else if (daddr !== ADDRS[n_rd]) begin
               $display("FAILED at %0t: daddr expected %h, got %h", $time, ADDRS[n_rd], daddr);
               errors++;
            end
            rd_addr = daddr;
            rd_wait = 1'b1;
            n_rd++;
         end else if (den && dwe) begin
            if (n_wr >= n_rd || rd_wait) begin
               report_error("write without a completed read before it");
            end else begin
               exp_word = (old_word & MASKS[n_wr]) | exp_data[n_wr];
               if (daddr !== rd_addr) begin
                  $display("FAILED at %0t: daddr expected %h, got %h", $time, rd_addr, daddr);
                  errors++;
               end
               if (di !== exp_word) begin
                  $display("FAILED at %0t: di expected %h, got %h", $time, exp_word, di);
                  errors++;
               end
            end
            n_wr++;
         end
         if (reconfig_done) begin
            if (!in_seq) begin
               report_error("reconfig_done with no reconfiguration running");
            end else begin
               if (n_wr != 6) begin
                  report_error($sformatf("%0d writes instead of six", n_wr));
               end
               $display("Row %0d done at %0t: %0d reads, %0d writes, %0d errors",
                        rows_done, $time, n_rd, n_wr, errors - row_err);
               rows_done++;
               in_seq = 1'b0;
            end
         end
         ready_q = ready;
         locked_q = locked;
      end
   end

endmodule

/* bench/drp_clock_model.sv */
`timescale 1ns/1ns

module drp_clock_model (
   input  logic                           dclk,
   input  logic                           rst,
   input  logic                           mmcm_rst,
   input  logic [drp_map_pkg::ADDR_W-1:0] daddr,
   input  logic [drp_map_pkg::DATA_W-1:0] di,
   input  logic                           den,
   input  logic                           dwe,
   output logic [drp_map_pkg::DATA_W-1:0] dout,
   output logic                           drdy,
   output logic                           locked
);

   logic [drp_map_pkg::DATA_W-1:0] regs [128];
   logic [drp_map_pkg::ADDR_W-1:0] acc_addr;
   logic [drp_map_pkg::DATA_W-1:0] acc_di;
   logic                           acc_we;
   logic                           busy;
   integer                         seed;
   int                             delay;
   int                             lock_cnt;

   initial begin
      seed = 68;
      dout = '0;
      drdy = 1'b0;
      locked = 1'b0;
      busy = 1'b0;
      for (int i = 0; i < 128; i++) begin
         regs[i] = 16'($random(seed));
      end
   end

   always @(posedge dclk) begin
      drdy <= 1'b0;
      // Lock is lost in reset and comes back 2 to 8 cycles later
      if (rst || mmcm_rst) begin
         locked   <= 1'b0;
         lock_cnt <= 2 + {$random(seed)} % 7;
      end else if (lock_cnt > 1) begin
         lock_cnt <= lock_cnt - 1;
      end else begin
         locked <= 1'b1;
      end
      if (den) begin
         busy     <= 1'b1;
         acc_addr <= daddr;
         acc_we   <= dwe;
         acc_di   <= di;
         delay    <= {$random(seed)} % 4;
      end else if (busy && delay > 0) begin
         delay <= delay - 1;
      end else if (busy) begin
         busy <= 1'b0;
         drdy <= 1'b1;
         if (acc_we) begin
            regs[acc_addr] <= acc_di;
         end else begin
            dout <= regs[acc_addr];
         end
      end
   end

endmodule

/* bench/reconfig_properties.sv */
`timescale 1ns/1ns

module reconfig_properties (
   input logic dclk,
   input logic rst,
   input logic den,
   input logic dwe,
   input logic drdy
);

   // Set by den and cleared by the matching drdy
   logic outstanding;
   // Kind of the last access, a write must follow a read
   logic last_we;

   always_ff @(posedge dclk) begin
      if (rst) begin
         outstanding <= 1'b0;
         last_we     <= 1'b1;
      end else if (den) begin
         outstanding <= 1'b1;
         last_we     <= dwe;
      end else if (drdy) begin
         outstanding <= 1'b0;
      end
   end

   a_den_pulse: assert property (@(posedge dclk) disable iff (rst) den |=> !den)
      else $error("den high for two cycles in a row");

   a_dwe_needs_den: assert property (@(posedge dclk) disable iff (rst)
                                     dwe |-> den && !last_we)
      else $error("dwe high without den or without a read before it");

   a_single_access: assert property (@(posedge dclk) disable iff (rst) den |-> !outstanding)
      else $error("new den before drdy of the outstanding access");

endmodule

bind drp_access_port reconfig_properties i_props (
   .dclk (dclk),
   .rst  (rst),
   .den  (den),
   .dwe  (dwe),
   .drdy (drdy)
);

/* rtl/mmcm_reconfig_top.sv */
`timescale 1ns/1ns

module mmcm_reconfig_top (
   input  logic                           dclk,
   input  logic                           rst,
   input  logic                           locked,
   input  logic                           start_reconfig,
   input  logic [5:0]                     clkout0_high_time,
   input  logic [5:0]                     clkout0_low_time,
   input  logic [2:0]                     clkout0_phase_mux,
   input  logic [2:0]                     clkout0_frac,
   input  logic                           clkout0_frac_en,
   input  logic                           clkout0_wf_r,
   input  logic                           clkout0_edge,
   input  logic                           clkout0_no_count,
   input  logic [5:0]                     clkout0_delay_time,
   input  logic [5:0]                     clkfbout_high_time,
   input  logic [5:0]                     clkfbout_low_time,
   input  logic [2:0]                     clkfbout_phase_mux,
   input  logic [2:0]                     clkfbout_frac,
   input  logic                           clkfbout_frac_en,
   input  logic                           clkfbout_wf_r,
   input  logic                           clkfbout_edge,
   input  logic                           clkfbout_no_count,
   input  logic [5:0]                     clkfbout_delay_time,
   input  logic [5:0]                     divclk_high_time,
   input  logic [5:0]                     divclk_low_time,
   input  logic                           divclk_edge,
   input  logic                           divclk_no_count,
   input  logic [drp_map_pkg::DATA_W-1:0] dout,
   input  logic                           drdy,
   output logic                           ready,
   output logic                           reconfig_done,
   output logic                           mmcm_rst,
   output logic [drp_map_pkg::ADDR_W-1:0] daddr,
   output logic [drp_map_pkg::DATA_W-1:0] di,
   output logic                           den,
   output logic                           dwe
);

   logic                           load;
   drp_map_pkg::step_t             step;
   reconfig_ctrl_pkg::port_cmd_t   cmd;
   logic                           rd_done;
   logic                           wr_done;
   logic [drp_map_pkg::ADDR_W-1:0] step_addr;
   logic [drp_map_pkg::DATA_W-1:0] step_mask;
   logic [drp_map_pkg::DATA_W-1:0] step_data;

   divider_word_builder i_words (
      .dclk                (dclk),
      .rst                 (rst),
      .load                (load),
      .step                (step),
      .clkout0_high_time   (clkout0_high_time),
      .clkout0_low_time    (clkout0_low_time),
      .clkout0_phase_mux   (clkout0_phase_mux),
      .clkout0_frac        (clkout0_frac),
      .clkout0_frac_en     (clkout0_frac_en),
      .clkout0_wf_r        (clkout0_wf_r),
      .clkout0_edge        (clkout0_edge),
      .clkout0_no_count    (clkout0_no_count),
      .clkout0_delay_time  (clkout0_delay_time),
      .clkfbout_high_time  (clkfbout_high_time),
      .clkfbout_low_time   (clkfbout_low_time),
      .clkfbout_phase_mux  (clkfbout_phase_mux),
      .clkfbout_frac       (clkfbout_frac),
      .clkfbout_frac_en    (clkfbout_frac_en),
      .clkfbout_wf_r       (clkfbout_wf_r),
      .clkfbout_edge       (clkfbout_edge),
      .clkfbout_no_count   (clkfbout_no_count),
      .clkfbout_delay_time (clkfbout_delay_time),
      .divclk_high_time    (divclk_high_time),
      .divclk_low_time     (divclk_low_time),
      .divclk_edge         (divclk_edge),
      .divclk_no_count     (divclk_no_count),
      .step_addr           (step_addr),
      .step_mask           (step_mask),
      .step_data           (step_data)
   );

   rmw_sequencer i_seq (
      .dclk           (dclk),
      .rst            (rst),
      .locked         (locked),
      .start_reconfig (start_reconfig),
      .rd_done        (rd_done),
      .wr_done        (wr_done),
      .load           (load),
      .step           (step),
      .cmd            (cmd),
      .mmcm_rst       (mmcm_rst),
      .ready          (ready),
      .reconfig_done  (reconfig_done)
   );

   drp_access_port i_port (
      .dclk      (dclk),
      .rst       (rst),
      .cmd       (cmd),
      .step_addr (step_addr),
      .step_mask (step_mask),
      .step_data (step_data),
      .dout      (dout),
      .drdy      (drdy),
      .daddr     (daddr),
      .di        (di),
      .den       (den),
      .dwe       (dwe),
      .rd_done   (rd_done),
      .wr_done   (wr_done)
   );

endmodule

/* rtl/drp_access_port.sv */
`timescale 1ns/1ns

module drp_access_port (
   input  logic                           dclk,
   input  logic                           rst,
   input  reconfig_ctrl_pkg::port_cmd_t   cmd,
   input  logic [drp_map_pkg::ADDR_W-1:0] step_addr,
   input  logic [drp_map_pkg::DATA_W-1:0] step_mask,
   input  logic [drp_map_pkg::DATA_W-1:0] step_data,
   input  logic [drp_map_pkg::DATA_W-1:0] dout,
   input  logic                           drdy,
   output logic [drp_map_pkg::ADDR_W-1:0] daddr,
   output logic [drp_map_pkg::DATA_W-1:0] di,
   output logic                           den,
   output logic                           dwe,
   output logic                           rd_done,
   output logic                           wr_done
);

   // Kind of the access still waiting for drdy
   reconfig_ctrl_pkg::port_cmd_t   pending;
   logic [drp_map_pkg::DATA_W-1:0] wr_word;
   logic                           rd_ack;

   assign rd_ack = drdy && (pending == reconfig_ctrl_pkg::CMD_READ);

   always_ff @(posedge dclk) begin
      if (rst) begin
         den     <= 1'b0;
         dwe     <= 1'b0;
         rd_done <= 1'b0;
         wr_done <= 1'b0;
         pending <= reconfig_ctrl_pkg::CMD_NONE;
      end else begin
         den     <= (cmd != reconfig_ctrl_pkg::CMD_NONE);
         dwe     <= (cmd == reconfig_ctrl_pkg::CMD_WRITE);
         rd_done <= rd_ack;
         wr_done <= drdy && (pending == reconfig_ctrl_pkg::CMD_WRITE);
         if (cmd != reconfig_ctrl_pkg::CMD_NONE) begin
            pending <= cmd;
         end else if (drdy) begin
            pending <= reconfig_ctrl_pkg::CMD_NONE;
         end
      end
   end

   always_ff @(posedge dclk) begin
      if (cmd != reconfig_ctrl_pkg::CMD_NONE) begin
         daddr <= step_addr;
      end
      if (cmd == reconfig_ctrl_pkg::CMD_WRITE) begin
         di <= wr_word;
      end
      // Mask and set in the same cycle the read data arrives
      if (rd_ack) begin
         wr_word <= (dout & step_mask) | step_data;
      end
   end

endmodule

/* rtl/rmw_sequencer.sv */
`timescale 1ns/1ns

module rmw_sequencer (
   input  logic                         dclk,
   input  logic                         rst,
   input  logic                         locked,
   input  logic                         start_reconfig,
   input  logic                         rd_done,
   input  logic                         wr_done,
   output logic                         load,
   output drp_map_pkg::step_t           step,
   output reconfig_ctrl_pkg::port_cmd_t cmd,
   output logic                         mmcm_rst,
   output logic                         ready,
   output logic                         reconfig_done
);

   reconfig_ctrl_pkg::seq_state_t state;

   assign ready = (state == reconfig_ctrl_pkg::WAIT_START);

   // Start is ignored unless ready
   assign load = ready && start_reconfig;

   always_comb begin
      case (state)
         reconfig_ctrl_pkg::READ:  cmd = reconfig_ctrl_pkg::CMD_READ;
         reconfig_ctrl_pkg::WRITE: cmd = reconfig_ctrl_pkg::CMD_WRITE;
         default:                  cmd = reconfig_ctrl_pkg::CMD_NONE;
      endcase
   end

   always_ff @(posedge dclk) begin
      if (rst) begin
         state         <= reconfig_ctrl_pkg::RESTART;
         step          <= drp_map_pkg::STEP_POWER;
         mmcm_rst      <= 1'b1;
         reconfig_done <= 1'b0;
      end else begin
         reconfig_done <= 1'b0;
         case (state)
            // Clock manager reset was held by rst or by a bad state
            reconfig_ctrl_pkg::RESTART: begin
               mmcm_rst <= 1'b0;
               state    <= reconfig_ctrl_pkg::WAIT_LOCK;
            end
            reconfig_ctrl_pkg::WAIT_LOCK: begin
               mmcm_rst <= 1'b0;
               step     <= drp_map_pkg::STEP_POWER;
               if (locked) begin
                  state <= reconfig_ctrl_pkg::WAIT_START;
               end
            end
            reconfig_ctrl_pkg::WAIT_START: begin
               if (load) begin
                  mmcm_rst <= 1'b1;
                  state    <= reconfig_ctrl_pkg::READ;
               end
            end
            reconfig_ctrl_pkg::READ: begin
               state <= reconfig_ctrl_pkg::WAIT_READ;
            end
            reconfig_ctrl_pkg::WAIT_READ: begin
               if (rd_done) begin
                  state <= reconfig_ctrl_pkg::WRITE;
               end
            end
            reconfig_ctrl_pkg::WRITE: begin
               state <= reconfig_ctrl_pkg::WAIT_WRITE;
            end
            reconfig_ctrl_pkg::WAIT_WRITE: begin
               if (wr_done) begin
                  if (step == drp_map_pkg::LAST_STEP) begin
                     // mmcm_rst drops one cycle later in WAIT_LOCK
                     reconfig_done <= 1'b1;
                     state         <= reconfig_ctrl_pkg::WAIT_LOCK;
                  end else begin
                     step  <= drp_map_pkg::step_t'(step + 3'd1);
                     state <= reconfig_ctrl_pkg::READ;
                  end
               end
            end
            default: begin
               mmcm_rst <= 1'b1;
               state    <= reconfig_ctrl_pkg::RESTART;
            end
         endcase
      end
   end

endmodule

/* rtl/divider_word_builder.sv */
`timescale 1ns/1ns

module divider_word_builder (
   input  logic                           dclk,
   input  logic                           rst,
   input  logic                           load,
   input  drp_map_pkg::step_t             step,
   input  logic [5:0]                     clkout0_high_time,
   input  logic [5:0]                     clkout0_low_time,
   input  logic [2:0]                     clkout0_phase_mux,
   input  logic [2:0]                     clkout0_frac,
   input  logic                           clkout0_frac_en,
   input  logic                           clkout0_wf_r,
   input  logic                           clkout0_edge,
   input  logic                           clkout0_no_count,
   input  logic [5:0]                     clkout0_delay_time,
   input  logic [5:0]                     clkfbout_high_time,
   input  logic [5:0]                     clkfbout_low_time,
   input  logic [2:0]                     clkfbout_phase_mux,
   input  logic [2:0]                     clkfbout_frac,
   input  logic                           clkfbout_frac_en,
   input  logic                           clkfbout_wf_r,
   input  logic                           clkfbout_edge,
   input  logic                           clkfbout_no_count,
   input  logic [5:0]                     clkfbout_delay_time,
   input  logic [5:0]                     divclk_high_time,
   input  logic [5:0]                     divclk_low_time,
   input  logic                           divclk_edge,
   input  logic                           divclk_no_count,
   output logic [drp_map_pkg::ADDR_W-1:0] step_addr,
   output logic [drp_map_pkg::DATA_W-1:0] step_mask,
   output logic [drp_map_pkg::DATA_W-1:0] step_data
);

   logic [drp_map_pkg::DATA_W-1:0] clkout0_w1;
   logic [drp_map_pkg::DATA_W-1:0] clkout0_w2;
   logic [drp_map_pkg::DATA_W-1:0] clkfbout_w1;
   logic [drp_map_pkg::DATA_W-1:0] clkfbout_w2;
   logic [drp_map_pkg::DATA_W-1:0] divclk_w;

   // Phase mux plus high and low counts
   function automatic logic [drp_map_pkg::DATA_W-1:0] pack_word1(
      input logic [2:0] phase_mux,
      input logic [5:0] high_time,
      input logic [5:0] low_time
   );
      return {phase_mux, 1'b0, high_time, low_time};
   endfunction

   // Fractional and edge controls
   function automatic logic [drp_map_pkg::DATA_W-1:0] pack_word2(
      input logic [2:0] frac,
      input logic       frac_en,
      input logic       wf_r,
      input logic       edge_bit,
      input logic       no_count,
      input logic [5:0] delay_time
   );
      return {1'b0, frac, frac_en, wf_r, 2'b00, edge_bit, no_count, delay_time};
   endfunction

   always_ff @(posedge dclk) begin
      if (rst) begin
         clkout0_w1  <= '0;
         clkout0_w2  <= '0;
         clkfbout_w1 <= '0;
         clkfbout_w2 <= '0;
         divclk_w    <= '0;
      end else if (load) begin
         clkout0_w1  <= pack_word1(clkout0_phase_mux, clkout0_high_time, clkout0_low_time);
         clkout0_w2  <= pack_word2(clkout0_frac, clkout0_frac_en, clkout0_wf_r,
                                   clkout0_edge, clkout0_no_count, clkout0_delay_time);
         clkfbout_w1 <= pack_word1(clkfbout_phase_mux, clkfbout_high_time, clkfbout_low_time);
         clkfbout_w2 <= pack_word2(clkfbout_frac, clkfbout_frac_en, clkfbout_wf_r,
                                   clkfbout_edge, clkfbout_no_count, clkfbout_delay_time);
         divclk_w    <= {2'b00, divclk_edge, divclk_no_count, divclk_high_time, divclk_low_time};
      end
   end

   always_comb begin
      case (step)
         drp_map_pkg::STEP_CLKOUT0_1: begin
            step_addr = drp_map_pkg::CLKOUT0_ADDR1;
            step_mask = drp_map_pkg::CLKOUT_MASK1;
            step_data = clkout0_w1;
         end
         drp_map_pkg::STEP_CLKOUT0_2: begin
            step_addr = drp_map_pkg::CLKOUT0_ADDR2;
            step_mask = drp_map_pkg::CLKOUT_MASK2;
            step_data = clkout0_w2;
         end
         drp_map_pkg::STEP_DIVCLK: begin
            step_addr = drp_map_pkg::DIVCLK_ADDR;
            step_mask = drp_map_pkg::DIVCLK_MASK;
            step_data = divclk_w;
         end
         drp_map_pkg::STEP_CLKFBOUT_1: begin
            step_addr = drp_map_pkg::CLKFBOUT_ADDR1;
            step_mask = drp_map_pkg::CLKOUT_MASK1;
            step_data = clkfbout_w1;
         end
         drp_map_pkg::STEP_CLKFBOUT_2: begin
            step_addr = drp_map_pkg::CLKFBOUT_ADDR2;
            step_mask = drp_map_pkg::CLKOUT_MASK2;
            step_data = clkfbout_w2;
         end
         // Power step and unused codes
         default: begin
            step_addr = drp_map_pkg::POWER_ADDR;
            step_mask = drp_map_pkg::POWER_MASK;
            step_data = drp_map_pkg::POWER_WORD;
         end
      endcase
   end

endmodule

/* rtl/reconfig_ctrl_pkg.sv */
package reconfig_ctrl_pkg;

   typedef enum logic [2:0] {
      RESTART,
      WAIT_LOCK,
      WAIT_START,
      READ,
      WAIT_READ,
      WRITE,
      WAIT_WRITE
   } seq_state_t;

   // Request from the sequencer to the port side
   typedef enum logic [1:0] {
      CMD_NONE,
      CMD_READ,
      CMD_WRITE
   } port_cmd_t;

endpackage

/* rtl/drp_map_pkg.sv */
package drp_map_pkg;

   localparam int DATA_W = 16;
   localparam int ADDR_W = 7;

   // Order of the read-modify-write cycles
   typedef enum logic [2:0] {
      STEP_POWER,
      STEP_CLKOUT0_1,
      STEP_CLKOUT0_2,
      STEP_DIVCLK,
      STEP_CLKFBOUT_1,
      STEP_CLKFBOUT_2
   } step_t;

   localparam step_t LAST_STEP = STEP_CLKFBOUT_2;

   // Register addresses
   localparam logic [ADDR_W-1:0] POWER_ADDR     = 7'h28;
   localparam logic [ADDR_W-1:0] CLKOUT0_ADDR1  = 7'h08;
   localparam logic [ADDR_W-1:0] CLKOUT0_ADDR2  = 7'h09;
   localparam logic [ADDR_W-1:0] DIVCLK_ADDR    = 7'h16;
   localparam logic [ADDR_W-1:0] CLKFBOUT_ADDR1 = 7'h14;
   localparam logic [ADDR_W-1:0] CLKFBOUT_ADDR2 = 7'h15;

   // Bits of the read word that survive the write
   localparam logic [DATA_W-1:0] POWER_MASK   = 16'h0000;
   localparam logic [DATA_W-1:0] CLKOUT_MASK1 = 16'h1000;
   localparam logic [DATA_W-1:0] CLKOUT_MASK2 = 16'h8000;
   localparam logic [DATA_W-1:0] DIVCLK_MASK  = 16'hC000;

   // All power bits on
   localparam logic [DATA_W-1:0] POWER_WORD = 16'hFFFF;

endpackage
